// ==== common/dram_rx_consts.svh ====
// ###################################################################
// DRAM receive path constants.
// Cache count, bus widths, block geometry and CDC FIFO depth.
// ###################################################################

`ifndef DRAM_RX_CONSTS_SVH
`define DRAM_RX_CONSTS_SVH

`default_nettype none

`define DRAM_RX_NUM_CACHE 4
`define DRAM_RX_DRAM_DATA_W 64
`define DRAM_RX_DMA_DATA_W 32
`define DRAM_RX_BLOCK_WORDS 8

// A block is split evenly over DRAM beats.
`define DRAM_RX_BEATS_PER_BLOCK \
  ((`DRAM_RX_BLOCK_WORDS * `DRAM_RX_DMA_DATA_W) / `DRAM_RX_DRAM_DATA_W)

`define DRAM_RX_CH_ADDR_W 8
`define DRAM_RX_FIFO_LG_SIZE 4  // Sixteen entries per CDC FIFO.

`default_nettype wire

`endif

// ==== common/dram_rx_pkg.sv ====
// ###################################################################
// DRAM receive path types.
// Beat, DMA word and channel address fields shared by all blocks.
// ###################################################################

`include "dram_rx_consts.svh"

`default_nettype none

package dram_rx_pkg;

  typedef logic [`DRAM_RX_DRAM_DATA_W-1:0] dram_beat_t;
  typedef logic [`DRAM_RX_DMA_DATA_W-1:0] dma_word_t;
  typedef logic [`DRAM_RX_CH_ADDR_W-1:0] ch_addr_t;

  // Cache id sits in the top address bits.
  typedef logic [$clog2(`DRAM_RX_NUM_CACHE)-1:0] cache_id_t;

  // Beat index sits in the low address bits.
  typedef logic [$clog2(`DRAM_RX_BEATS_PER_BLOCK)-1:0] beat_idx_t;

endpackage

`default_nettype wire

// ==== logic/dram_rx_async_fifo.sv ====
// ###################################################################
// Dual-clock FIFO for the DRAM receive path.
// Gray pointers cross through two-flop synchronizers in each direction.
// ###################################################################

`timescale 1ns/1ns

`include "dram_rx_consts.svh"

`default_nettype none

module dram_rx_async_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int lg_size_p = `DRAM_RX_FIFO_LG_SIZE
) (
  input  wire logic     w_clk_i,
  input  wire logic     r_clk_i,
  input  wire logic     reset_i,
  input  wire logic     w_enq_i,
  input  wire payload_t w_data_i,
  output logic          w_full_o,
  input  wire logic     r_deq_i,
  output payload_t      r_data_o,
  output logic          r_valid_o
);

  localparam int depth_lp = 1 << lg_size_p;

  // One extra bit tells a full FIFO from an empty one.
  typedef logic [lg_size_p:0] ptr_t;

  payload_t mem_r [depth_lp];

  ptr_t w_ptr_bin_r;
  ptr_t w_ptr_bin_next;
  ptr_t w_ptr_gray_r;
  ptr_t r_gray_sync1_r;
  ptr_t r_gray_sync2_r;

  ptr_t r_ptr_bin_r;
  ptr_t r_ptr_bin_next;
  ptr_t r_ptr_gray_r;
  ptr_t w_gray_sync1_r;
  ptr_t w_gray_sync2_r;

  logic w_push;
  logic r_pop;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // ###################################################################
  // Write domain
  // ###################################################################

  assign w_push = w_enq_i & ~w_full_o;
  assign w_ptr_bin_next = w_ptr_bin_r + ptr_t'(w_push);

  always_ff @(posedge w_clk_i) begin
    if (reset_i) begin
      w_ptr_bin_r <= '0;
      w_ptr_gray_r <= '0;
      r_gray_sync1_r <= '0;
      r_gray_sync2_r <= '0;
    end else begin
      w_ptr_bin_r <= w_ptr_bin_next;
      w_ptr_gray_r <= bin2gray(w_ptr_bin_next);  // Registered so it is glitch free.
      r_gray_sync1_r <= r_ptr_gray_r;
      r_gray_sync2_r <= r_gray_sync1_r;
    end
  end

  always_ff @(posedge w_clk_i) begin
    if (w_push) begin
      mem_r[w_ptr_bin_r[lg_size_p-1:0]] <= w_data_i;
    end
  end

  // Full when the writer is one lap ahead. In Gray code that flips the two top bits.
  assign w_full_o = (w_ptr_gray_r ==
                     {~r_gray_sync2_r[lg_size_p -: 2], r_gray_sync2_r[lg_size_p-2:0]});

  // ###################################################################
  // Read domain
  // ###################################################################

  assign r_valid_o = (r_ptr_gray_r != w_gray_sync2_r);
  assign r_pop = r_deq_i & r_valid_o;
  assign r_ptr_bin_next = r_ptr_bin_r + ptr_t'(r_pop);
  assign r_data_o = mem_r[r_ptr_bin_r[lg_size_p-1:0]];

  always_ff @(posedge r_clk_i) begin
    if (reset_i) begin
      r_ptr_bin_r <= '0;
      r_ptr_gray_r <= '0;
      w_gray_sync1_r <= '0;
      w_gray_sync2_r <= '0;
    end else begin
      r_ptr_bin_r <= r_ptr_bin_next;
      r_ptr_gray_r <= bin2gray(r_ptr_bin_next);
      w_gray_sync1_r <= w_ptr_gray_r;
      w_gray_sync2_r <= w_gray_sync1_r;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dram_rx_steer.sv ====
// ###################################################################
// Steering controller.
// Pairs the FIFO heads and routes each beat to its cache's buffer.
// ###################################################################

`timescale 1ns/1ns

`include "dram_rx_consts.svh"

`default_nettype none

module dram_rx_steer (
  input  wire logic                            addr_v_i,
  input  wire logic                            data_v_i,
  input  wire dram_rx_pkg::ch_addr_t           ch_addr_i,
  input  wire logic [`DRAM_RX_NUM_CACHE-1:0]   load_ready_i,
  output logic                                 pop_o,
  output logic [`DRAM_RX_NUM_CACHE-1:0]        load_v_o,
  output dram_rx_pkg::beat_idx_t               beat_idx_o
);

  localparam int addr_w_lp = $bits(dram_rx_pkg::ch_addr_t);
  localparam int id_w_lp = $bits(dram_rx_pkg::cache_id_t);

  dram_rx_pkg::cache_id_t cache_id;
  logic pair_v;
  logic accept;

  assign cache_id = ch_addr_i[addr_w_lp-1 -: id_w_lp];
  assign beat_idx_o = ch_addr_i[$bits(dram_rx_pkg::beat_idx_t)-1:0];

  // Both heads belong to the same beat, so they are consumed together.
  assign pair_v = addr_v_i & data_v_i;
  assign accept = pair_v & load_ready_i[cache_id];  // A busy target blocks the head.

  assign pop_o = accept;

  always_comb begin
    load_v_o = '0;
    load_v_o[cache_id] = accept;
  end

endmodule

`default_nettype wire

// ==== reorder/dram_rx_reorder.sv ====
// ###################################################################
// Per-cache reorder buffer.
// Gathers the beats of one block in any order and streams it as DMA
// words once every beat is present.
// ###################################################################

`timescale 1ns/1ns

`include "dram_rx_consts.svh"

`default_nettype none

module dram_rx_reorder (
  input  wire logic                    core_clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    load_v_i,
  input  wire dram_rx_pkg::beat_idx_t  beat_idx_i,
  input  wire dram_rx_pkg::dram_beat_t beat_i,
  output logic                         load_ready_o,
  output dram_rx_pkg::dma_word_t       dma_data_o,
  output logic                         dma_data_v_o,
  input  wire logic                    dma_data_ready_and_i
);

  localparam int beats_lp = `DRAM_RX_BEATS_PER_BLOCK;
  localparam int words_lp = `DRAM_RX_BLOCK_WORDS;
  localparam int word_cnt_w_lp = $clog2(words_lp);

  typedef enum logic {
    fill_s,
    stream_s
  } state_e;

  state_e state_r;
  logic [beats_lp-1:0] mask_r;
  logic [beats_lp-1:0] mask_next;
  logic [word_cnt_w_lp-1:0] word_cnt_r;
  logic xfer;
  logic last_word;

  dram_rx_pkg::dram_beat_t [beats_lp-1:0] beat_r;
  dram_rx_pkg::dma_word_t [words_lp-1:0] block_words;

  // ###################################################################
  // Beat storage
  // ###################################################################

  always_ff @(posedge core_clk_i) begin
    if (load_v_i) begin
      beat_r[beat_idx_i] <= beat_i;
    end
  end

  // Beat b holds word 2b low and 2b+1 high, so the packed view is in word order.
  assign block_words = beat_r;

  always_comb begin
    mask_next = mask_r;
    if (load_v_i) begin
      mask_next[beat_idx_i] = 1'b1;
    end
  end

  // ###################################################################
  // Fill and stream control
  // ###################################################################

  assign xfer = dma_data_v_o & dma_data_ready_and_i;
  assign last_word = (word_cnt_r == word_cnt_w_lp'(words_lp - 1));

  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      state_r <= fill_s;
      mask_r <= '0;
      word_cnt_r <= '0;
    end else begin
      case (state_r)
        fill_s: begin
          mask_r <= mask_next;
          if (&mask_next) begin
            state_r <= stream_s;  // Last missing beat just arrived.
          end
        end
        stream_s: begin
          if (xfer) begin
            word_cnt_r <= word_cnt_r + 1'b1;
            if (last_word) begin
              state_r <= fill_s;
              mask_r <= '0;
              word_cnt_r <= '0;
            end
          end
        end
        default: state_r <= fill_s;
      endcase
    end
  end

  assign load_ready_o = (state_r == fill_s);
  assign dma_data_v_o = (state_r == stream_s);
  assign dma_data_o = block_words[word_cnt_r];

endmodule

`default_nettype wire

// ==== logic/dram_rx_top.sv ====
// ###################################################################
// DRAM receive path top level.
// Crosses beats into the core domain and feeds one reorder buffer
// per cache.
// ###################################################################

`timescale 1ns/1ns

`include "dram_rx_consts.svh"

`default_nettype none

module dram_rx_top (
  input  wire logic                                   core_clk_i,
  input  wire logic                                   dram_clk_i,
  input  wire logic                                   reset_i,
  input  wire logic                                   dram_data_v_i,
  input  wire dram_rx_pkg::dram_beat_t                dram_data_i,
  input  wire dram_rx_pkg::ch_addr_t                  dram_ch_addr_i,
  input  wire logic [`DRAM_RX_NUM_CACHE-1:0]          dma_data_ready_and_i,
  output dram_rx_pkg::dma_word_t [`DRAM_RX_NUM_CACHE-1:0] dma_data_o,
  output logic [`DRAM_RX_NUM_CACHE-1:0]               dma_data_v_o
);

  // Full flags are watched by the checker. The DRAM side has no back-pressure.
  logic data_afifo_full;
  logic addr_afifo_full;

  dram_rx_pkg::dram_beat_t fifo_beat;
  dram_rx_pkg::ch_addr_t fifo_addr;
  logic fifo_beat_v;
  logic fifo_addr_v;
  logic pop;

  logic [`DRAM_RX_NUM_CACHE-1:0] load_v;
  logic [`DRAM_RX_NUM_CACHE-1:0] load_ready;
  dram_rx_pkg::beat_idx_t beat_idx;

  dram_rx_async_fifo #(
    .payload_t(dram_rx_pkg::dram_beat_t)
  ) data_afifo (
    .w_clk_i(dram_clk_i),
    .r_clk_i(core_clk_i),
    .reset_i(reset_i),
    .w_enq_i(dram_data_v_i),
    .w_data_i(dram_data_i),
    .w_full_o(data_afifo_full),
    .r_deq_i(pop),
    .r_data_o(fifo_beat),
    .r_valid_o(fifo_beat_v)
  );

  dram_rx_async_fifo #(
    .payload_t(dram_rx_pkg::ch_addr_t)
  ) addr_afifo (
    .w_clk_i(dram_clk_i),
    .r_clk_i(core_clk_i),
    .reset_i(reset_i),
    .w_enq_i(dram_data_v_i),
    .w_data_i(dram_ch_addr_i),
    .w_full_o(addr_afifo_full),
    .r_deq_i(pop),
    .r_data_o(fifo_addr),
    .r_valid_o(fifo_addr_v)
  );

  dram_rx_steer steer (
    .addr_v_i(fifo_addr_v),
    .data_v_i(fifo_beat_v),
    .ch_addr_i(fifo_addr),
    .load_ready_i(load_ready),
    .pop_o(pop),
    .load_v_o(load_v),
    .beat_idx_o(beat_idx)
  );

  for (genvar i = 0; i < `DRAM_RX_NUM_CACHE; i++) begin : g_reorder
    dram_rx_reorder reorder (
      .core_clk_i(core_clk_i),
      .reset_i(reset_i),
      .load_v_i(load_v[i]),
      .beat_idx_i(beat_idx),
      .beat_i(fifo_beat),
      .load_ready_o(load_ready[i]),
      .dma_data_o(dma_data_o[i]),
      .dma_data_v_o(dma_data_v_o[i]),
      .dma_data_ready_and_i(dma_data_ready_and_i[i])
    );
  end

endmodule

`default_nettype wire

// ==== verification/dram_rx_chk.sv ====
// ###################################################################
// Protocol checker for the DRAM receive path, bound into the top level.
// Watches FIFO overrun, one-hot steering and DMA output stability.
// ###################################################################

`timescale 1ns/1ns

`include "dram_rx_consts.svh"

`default_nettype none

module dram_rx_chk (
  input wire logic                                        core_clk_i,
  input wire logic                                        dram_clk_i,
  input wire logic                                        reset_i,
  input wire logic                                        dram_data_v_i,
  input wire logic                                        data_full_i,
  input wire logic                                        addr_full_i,
  input wire logic [`DRAM_RX_NUM_CACHE-1:0]               load_v_i,
  input wire dram_rx_pkg::dma_word_t [`DRAM_RX_NUM_CACHE-1:0] dma_data_i,
  input wire logic [`DRAM_RX_NUM_CACHE-1:0]               dma_data_v_i,
  input wire logic [`DRAM_RX_NUM_CACHE-1:0]               dma_ready_i
);

  int fail_cnt = 0;

  // The DRAM side has no ready, so a beat must always find room.
  no_overrun: assert property (@(posedge dram_clk_i) disable iff (reset_i)
    dram_data_v_i |-> !(data_full_i || addr_full_i))
    else begin
      $error("DRAM beat written while a CDC FIFO was full.");
      fail_cnt++;
    end

  one_target: assert property (@(posedge core_clk_i) disable iff (reset_i)
    $onehot0(load_v_i))
    else begin
      $error("More than one reorder buffer loaded in the same cycle.");
      fail_cnt++;
    end

  for (genvar i = 0; i < `DRAM_RX_NUM_CACHE; i++) begin : g_hold
    hold_stable: assert property (@(posedge core_clk_i) disable iff (reset_i)
      dma_data_v_i[i] && !dma_ready_i[i] |=> dma_data_v_i[i] && $stable(dma_data_i[i]))
      else begin
        $error("DMA lane dropped valid or changed data while stalled.");
        fail_cnt++;
      end
  end

endmodule

bind dram_rx_top dram_rx_chk chk_inst (
  .core_clk_i(core_clk_i),
  .dram_clk_i(dram_clk_i),
  .reset_i(reset_i),
  .dram_data_v_i(dram_data_v_i),
  .data_full_i(data_afifo_full),
  .addr_full_i(addr_afifo_full),
  .load_v_i(load_v),
  .dma_data_i(dma_data_o),
  .dma_data_v_i(dma_data_v_o),
  .dma_ready_i(dma_data_ready_and_i)
);

`default_nettype wire

// ==== verification/dram_rx_tb.sv ====
// ###################################################################
// Testbench for the DRAM receive path.
// Directed tests with a per-cache queue of expected DMA words.
// ###################################################################

`timescale 1ns/1ns

`include "dram_rx_consts.svh"

`default_nettype none

module dram_rx_tb;

  localparam int num_cache_lp = `DRAM_RX_NUM_CACHE;
  localparam int beats_lp = `DRAM_RX_BEATS_PER_BLOCK;
  localparam int cycle_limit_lp = 4000;

  logic core_clk = 1'b0;
  logic dram_clk = 1'b0;
  logic reset;
  logic dram_v;
  dram_rx_pkg::dram_beat_t dram_data;
  dram_rx_pkg::ch_addr_t dram_addr;
  logic [num_cache_lp-1:0] dma_ready;
  dram_rx_pkg::dma_word_t [num_cache_lp-1:0] dma_data;
  logic [num_cache_lp-1:0] dma_v;

  int seed = 32'h55603a55;
  int err_cnt = 0;
  int check_cnt = 0;
  int cycle_cnt = 0;

  dram_rx_pkg::dram_beat_t blk [num_cache_lp][beats_lp];  // Block being sent, per cache.
  dram_rx_pkg::dma_word_t exp_q [num_cache_lp][$];

  always #10 core_clk = ~core_clk;
  always #7 dram_clk = ~dram_clk;

  dram_rx_top dram_rx_top_inst (
    .core_clk_i(core_clk),
    .dram_clk_i(dram_clk),
    .reset_i(reset),
    .dram_data_v_i(dram_v),
    .dram_data_i(dram_data),
    .dram_ch_addr_i(dram_addr),
    .dma_data_ready_and_i(dma_ready),
    .dma_data_o(dma_data),
    .dma_data_v_o(dma_v)
  );

  // ###################################################################
  // Reference model and stimulus
  // ###################################################################

  function automatic dram_rx_pkg::dram_beat_t pattern_beat(input int tag, input int cache,
                                                           input int b);
    return {8'(tag), 8'(cache), 8'hA5, 8'(2*b+1), 8'(tag), 8'(cache), 8'h5A, 8'(2*b)};
  endfunction

  task automatic fill_pattern(input int tag, input int cache);
    for (int b = 0; b < beats_lp; b++) begin
      blk[cache][b] = pattern_beat(tag, cache, b);
    end
  endtask

  task automatic fill_random(input int cache);
    for (int b = 0; b < beats_lp; b++) begin
      blk[cache][b] = {$random(seed), $random(seed)};
    end
  endtask

  // Beat b yields word 2b from its low half and word 2b+1 from its high half.
  task automatic expect_block(input int cache);
    for (int b = 0; b < beats_lp; b++) begin
      exp_q[cache].push_back(blk[cache][b][31:0]);
      exp_q[cache].push_back(blk[cache][b][63:32]);
    end
  endtask

  task automatic send_beat(input int cache, input int b);
    @(negedge dram_clk);
    dram_v = 1'b1;
    dram_data = blk[cache][b];
    dram_addr = {2'(cache), 4'(b + 3), 2'(b)};  // Middle bits are don't-care.
    @(negedge dram_clk);
    dram_v = 1'b0;
  endtask

  task automatic collect_lane(input int lane, input bit rnd);
    int n;
    dram_rx_pkg::dma_word_t want;
    n = 0;
    while (exp_q[lane].size() > 0) begin
      @(negedge core_clk);
      dma_ready[lane] = rnd ? 1'($random(seed)) : 1'b1;
      if (dma_ready[lane] && dma_v[lane]) begin
        want = exp_q[lane].pop_front();
        check_cnt++;
        assert (dma_data[lane] == want) else begin
          err_cnt++;
          $display("Fail at %0t ns: lane %0d word %0d got %h, expected %h",
                   $time, lane, n, dma_data[lane], want);
        end
        n++;
      end
    end
    @(negedge core_clk);
    dma_ready[lane] = 1'b0;
  endtask

  task automatic collect_all(input bit rnd);
    for (int l = 0; l < num_cache_lp; l++) begin
      fork
        automatic int lane = l;
        collect_lane(lane, rnd);
      join_none
    end
    wait fork;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge core_clk);
      check_cnt++;
      assert (dma_v == '0) else begin
        err_cnt++;
        $display("Fail at %0t ns: unexpected DMA valid %b", $time, dma_v);
      end
    end
  endtask

  // ###################################################################
  // Tests
  // ###################################################################

  task automatic test_idle_after_reset();
    check_idle(20);
  endtask

  task automatic test_in_order();
    fill_pattern(2, 0);
    expect_block(0);
    for (int b = 0; b < beats_lp; b++) send_beat(0, b);
    collect_all(1'b0);
    check_idle(4);
  endtask

  task automatic test_shuffled();
    int order [beats_lp] = '{2, 0, 3, 1};
    fill_pattern(3, 1);
    expect_block(1);
    for (int k = 0; k < beats_lp; k++) send_beat(1, order[k]);
    collect_all(1'b0);
    check_idle(4);
  endtask

  task automatic test_all_caches();
    for (int c = 0; c < num_cache_lp; c++) begin
      fill_pattern(4, c);
      expect_block(c);
    end
    for (int b = 0; b < beats_lp; b++) begin
      for (int c = 0; c < num_cache_lp; c++) send_beat(c, (b + c) % beats_lp);
    end
    collect_all(1'b0);
    check_idle(4);
  endtask

  // Both rounds are sent before any lane is ready, so each lane holds two blocks at once.
  // The second round waits in the CDC FIFOs behind the full buffers.
  task automatic test_random_ready();
    for (int r = 0; r < 2; r++) begin
      for (int c = 0; c < num_cache_lp; c++) begin
        fill_random(c);
        expect_block(c);
      end
      for (int b = 0; b < beats_lp; b++) begin
        for (int c = 0; c < num_cache_lp; c++) send_beat(c, (b + c + r) % beats_lp);
      end
    end
    collect_all(1'b1);
    check_idle(4);
  endtask

  task automatic test_back_to_back();
    for (int k = 0; k < 2; k++) begin
      fill_pattern(6 + k, 3);
      expect_block(3);
      for (int b = 0; b < beats_lp; b++) send_beat(3, b);
    end
    collect_all(1'b0);
    check_idle(4);
  endtask

  // ###################################################################
  // Run control
  // ###################################################################

  initial begin
    while (cycle_cnt < cycle_limit_lp) begin
      @(posedge core_clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d core cycles.", cycle_limit_lp);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    reset = 1'b1;
    dram_v = 1'b0;
    dram_data = '0;
    dram_addr = '0;
    dma_ready = '0;
    repeat (5) @(posedge core_clk);
    @(negedge core_clk);
    reset = 1'b0;

    test_idle_after_reset();
    test_in_order();
    test_shuffled();
    test_all_caches();
    test_random_ready();
    test_back_to_back();

    $display("Checks: %0d, check errors: %0d, assertion errors: %0d",
             check_cnt, err_cnt, dram_rx_top_inst.chk_inst.fail_cnt);
    if (err_cnt == 0 && dram_rx_top_inst.chk_inst.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/dram_rx_pkg.sv
logic/dram_rx_async_fifo.sv
logic/dram_rx_steer.sv
reorder/dram_rx_reorder.sv
logic/dram_rx_top.sv
verification/dram_rx_chk.sv
verification/dram_rx_tb.sv

// ==== Bender.yml ====
package:
  name: dram_rx

sources:
  - include_dirs:
      - common
    files:
      - common/dram_rx_pkg.sv
      - logic/dram_rx_async_fifo.sv
      - logic/dram_rx_steer.sv
      - reorder/dram_rx_reorder.sv
      - logic/dram_rx_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/dram_rx_chk.sv
      - verification/dram_rx_tb.sv
